// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_cmt
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== bench/tb_cmt.sv ====
`timescale 1ns/10ps

module tb_cmt
   import cmt_pkg::*;
;
   localparam int p_cw       = 2;
   localparam int cw         = 1 << p_cw;
   localparam int half_per   = 5;
   localparam int clk_per    = 2 * half_per;
   localparam int rst_cycles = 10;
   localparam int n_instr    = 3000;
   localparam int rob_depth  = 8;
   localparam int wd_ns      = n_instr * 8 * clk_per + rst_cycles * clk_per;

   logic                clk = 1'b0;
   logic                rst_n;
   cmt_slot_t [cw-1:0]  slots;
   unit_rsp_t           unit_rsp;
   logic [cw-1:0]       fire;
   logic [p_cw:0]       pop_size;
   unit_req_t           unit_req;
   prf_wr_t             prf_wr;
   bpu_upd_t            bpu;
   redirect_t           redirect;

   cmt_slot_t           rob_q[$];   // ROB model, head at index 0
   cmt_slot_t [cw-1:0]  cur_slots;
   unit_rsp_t           cur_rsp;
   logic                se_q;       // Expected mispredict flush
   logic [pc_w-1:0]     se_tgt;
   logic                u_busy;     // Unit model has an operation in flight
   int                  u_cnt;
   logic                u_epu;
   int                  gen_count;
   int                  retired;
   int                  n_flush;
   int                  cyc;
   string               test_name;

   cmt_top #(.p_cw(p_cw)) dut0
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .slots    (slots),
      .unit_rsp (unit_rsp),
      .fire     (fire),
      .pop_size (pop_size),
      .unit_req (unit_req),
      .prf_wr   (prf_wr),
      .bpu      (bpu),
      .redirect (redirect)
   );

   always #(half_per) clk = ~clk;

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic fire_compare(string name, logic [cw-1:0] exp, logic [cw-1:0] act);
      if (exp !== act)
      begin
         $display("Mismatch in %s: fire expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic pop_compare(string name, logic [p_cw:0] exp, logic [p_cw:0] act);
      if (exp !== act)
      begin
         $display("Mismatch in %s: pop_size expected %0d, actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic request_compare(string name, unit_req_t exp, unit_req_t act);
      logic bad;
      bad = (exp.lsu_valid !== act.lsu_valid) || (exp.epu_valid !== act.epu_valid);
      if (exp.lsu_valid || exp.epu_valid)   // Payload only matters with a strobe
         bad = bad || (exp !== act);
      if (bad)
      begin
         $display("Mismatch in %s: unit_req expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic prf_compare(string name, prf_wr_t exp, prf_wr_t act);
      if (exp.we !== act.we || (exp.we && exp !== act))
      begin
         $display("Mismatch in %s: prf_wr expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic bpu_compare(string name, bpu_upd_t exp, bpu_upd_t act);
      if (exp.valid !== act.valid || (exp.valid && exp !== act))
      begin
         $display("Mismatch in %s: bpu expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic redirect_compare(string name, redirect_t exp, redirect_t act);
      if (exp.flush !== act.flush || (exp.flush && exp !== act))
      begin
         $display("Mismatch in %s: redirect expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   function automatic cmt_slot_t make_slot();
      cmt_slot_t s;
      int        kind;
      s            = '0;
      s.valid      = 1'b1;
      s.pc         = $urandom;
      s.prd        = prf_aw'($urandom);
      s.prd_we     = 1'($urandom);
      s.opera      = $urandom;
      s.operb      = $urandom;
      s.pred_taken = 1'($urandom);
      s.pred_tgt   = $urandom;
      kind         = int'($urandom % 10);
      case (kind)
         4: s.lsu_op = lsu_load;
         5:
         begin
            s.lsu_op = lsu_store;
            s.prd_we = 1'b0;              // Stores write no register
         end
         6: s.epu_op = epu_op_e'(2'(1 + $urandom % 3));
         7: s.exc = 1'b1;                 // Goes to the EPU as well
         8, 9:
         begin
            s.br_kind = br_kind_e'(2'(1 + $urandom % 3));
            s.fls     = ($urandom % 3 == 0);
         end
         default: ;                       // Plain ALU result
      endcase
      return s;
   endfunction

   // Refill the ROB, present its head and the unit answer
   task automatic drive_cycle();
      int add;
      if (cyc >= 5 && gen_count < n_instr)
      begin
         add = int'($urandom % 3);
         while (add > 0 && rob_q.size() < rob_depth && gen_count < n_instr)
         begin
            rob_q.push_back(make_slot());
            gen_count++;
            add--;
         end
      end
      for (int i = 0; i < cw; i++)
         cur_slots[i] = (i < rob_q.size()) ? rob_q[i] : '0;
      cur_rsp = '0;
      if (u_busy && u_cnt > 0)
      begin
         u_cnt--;
         if (u_cnt == 0)
         begin
            if (u_epu)
            begin
               cur_rsp.epu_done = 1'b1;
               cur_rsp.epu_dout = $urandom;
               cur_rsp.exc      = ($urandom % 5 == 0);
               cur_rsp.exc_tgt  = $urandom;
            end
            else
            begin
               cur_rsp.lsu_done = 1'b1;
               cur_rsp.lsu_dout = $urandom;
            end
         end
      end
      slots    <= cur_slots;
      unit_rsp <= cur_rsp;
   endtask

   // Expected results from the commit rules, then model update
   task automatic expect_cycle();
      logic [cw-1:0] single;
      logic [cw-1:0] exp_fire;
      logic          lreq;
      logic          ereq;
      logic          done;
      logic          flush_e;
      logic          run;
      int            n_fire;
      unit_req_t     exp_req;
      prf_wr_t       exp_wr;
      bpu_upd_t      exp_bpu;
      redirect_t     exp_rd;
      cmt_slot_t     s0;
      s0 = cur_slots[0];
      for (int i = 0; i < cw; i++)
         single[i] = (cur_slots[i].lsu_op != lsu_none) || (cur_slots[i].epu_op != epu_none) ||
                     cur_slots[i].exc || cur_slots[i].fls || (cur_slots[i].br_kind != br_none);
      lreq    = !se_q && s0.valid && (s0.lsu_op != lsu_none);
      ereq    = !se_q && s0.valid && ((s0.epu_op != epu_none) || s0.exc);
      done    = cur_rsp.lsu_done || cur_rsp.epu_done;
      flush_e = se_q || (cur_rsp.epu_done && cur_rsp.exc);
      run     = (!(lreq || ereq) || done) && !flush_e;
      n_fire  = 0;
      for (int j = 0; j < cw; j++)
      begin
         run         = run && cur_slots[j].valid && (j == 0 || !single[j]);
         exp_fire[j] = run;
         if (run)
            n_fire++;
      end
      exp_req           = '0;
      exp_req.lsu_valid = !u_busy && lreq;
      exp_req.epu_valid = !u_busy && ereq;
      exp_req.lsu_op    = s0.lsu_op;
      exp_req.epu_op    = s0.epu_op;
      exp_req.opera     = s0.opera;
      exp_req.operb     = s0.operb;
      exp_req.pc        = s0.pc;
      exp_req.npc       = s0.pc + 1;
      exp_wr.we   = done && !flush_e && s0.prd_we;
      exp_wr.addr = s0.prd;
      exp_wr.data = cur_rsp.epu_done ? cur_rsp.epu_dout : cur_rsp.lsu_dout;
      exp_bpu.valid   = exp_fire[0] && (s0.br_kind != br_none);
      exp_bpu.kind    = s0.br_kind;
      exp_bpu.taken   = s0.pred_taken ^ s0.fls;
      exp_bpu.pc      = s0.pc;
      exp_bpu.npc_act = s0.fls ? s0.opera : s0.pred_tgt;
      exp_rd.flush = flush_e;
      exp_rd.tgt   = se_q ? se_tgt : cur_rsp.exc_tgt;

      for (int j = 1; j < cw; j++)
      begin
         if (fire[j] && single[j])
         begin
            $display("Single-unit operation fired from slot %0d in %s", j, test_name);
            abort_run();
         end
      end
      if (se_q && (fire != '0 || unit_req.lsu_valid || unit_req.epu_valid))
      begin
         $display("Commit or request seen in the cycle after a mispredict in %s", test_name);
         abort_run();
      end
      fire_compare(test_name, exp_fire, fire);
      pop_compare(test_name, (p_cw+1)'(n_fire), pop_size);
      request_compare(test_name, exp_req, unit_req);
      prf_compare(test_name, exp_wr, prf_wr);
      bpu_compare(test_name, exp_bpu, bpu);
      redirect_compare(test_name, exp_rd, redirect);

      if (exp_req.lsu_valid || exp_req.epu_valid)
      begin
         u_busy = 1'b1;
         u_cnt  = 1 + int'($urandom % 4);   // Latency of 1 to 4 cycles
         u_epu  = exp_req.epu_valid;
      end
      if (done)
         u_busy = 1'b0;
      if (exp_fire[0])
         se_tgt = s0.opera;
      se_q = exp_fire[0] && s0.fls;
      for (int k = 0; k < n_fire; k++)
         void'(rob_q.pop_front());
      retired += n_fire;
      if (flush_e)
      begin
         rob_q.delete();                    // Front end refetches
         n_flush++;
      end
   endtask

   initial
   begin
      #(wd_ns);
      $display("Watchdog expired after %0d ns without finishing", wd_ns);
      abort_run();
   end

   initial
   begin
      void'($urandom(62955));
      rst_n     = 1'b0;
      slots     = '0;
      unit_rsp  = '0;
      cur_slots = '0;
      cur_rsp   = '0;
      se_q      = 1'b0;
      se_tgt    = '0;
      u_busy    = 1'b0;
      u_cnt     = 0;
      u_epu     = 1'b0;
      gen_count = 0;
      retired   = 0;
      n_flush   = 0;
      cyc       = 0;
      test_name = "post-reset idle";
      repeat (rst_cycles) @(posedge clk);
      rst_n <= 1'b1;
      while (gen_count < n_instr || rob_q.size() != 0 || u_busy || se_q)
      begin
         @(posedge clk);
         if (cyc == 5)
            test_name = "random commit";
         drive_cycle();
         @(negedge clk);
         expect_cycle();
         cyc++;
      end
      $display("Retired %0d of %0d instructions, %0d flushes", retired, gen_count, n_flush);
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== build.f ====
src/cmt_pkg.sv
src/cmt_select.sv
src/cmt_unit_req.sv
src/cmt_branch_resolve.sv
src/cmt_top.sv
bench/tb_cmt.sv

// ==== src/cmt_branch_resolve.sv ====
`timescale 1ns/10ps

module cmt_branch_resolve
   import cmt_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      fire0,
   input  cmt_slot_t slot0,
   input  unit_rsp_t unit_rsp,
   output logic      se_flush,
   output logic      flush,
   output redirect_t redirect,
   output bpu_upd_t  bpu
);
   logic            se_flush_q;
   logic [pc_w-1:0] se_tgt_q;
   logic            exc_flush;
   logic            is_br0;
   logic [pc_w-1:0] fls_tgt;

   assign fls_tgt = slot0.opera[pc_w-1:0];   // Resolved target of slot 0

   // Mispredict flush, one-cycle pulse after the branch retires
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         se_flush_q <= 1'b0;
      else
         se_flush_q <= fire0 & slot0.fls;
   end

   always_ff @(posedge clk)
   begin
      if (fire0)
         se_tgt_q <= fls_tgt;
   end

   assign se_flush = se_flush_q;

   // Exception comes straight from the EPU
   assign exc_flush = unit_rsp.epu_done & unit_rsp.exc;

   assign flush = se_flush_q | exc_flush;

   always_comb
   begin
      redirect.flush = flush;
      if (se_flush_q)
         redirect.tgt = se_tgt_q;   // Older instruction wins
      else
         redirect.tgt = unit_rsp.exc_tgt;
   end

   assign is_br0 = (slot0.br_kind != br_none);

   // Predictor update on branch retire
   always_comb
   begin
      bpu.valid = fire0 & is_br0;
      bpu.kind  = slot0.br_kind;
      bpu.taken = slot0.pred_taken ^ slot0.fls;   // Flip direction on mispredict
      bpu.pc    = slot0.pc;
      if (slot0.fls)
         bpu.npc_act = fls_tgt;
      else
         bpu.npc_act = slot0.pred_tgt;
   end

endmodule

// ==== src/cmt_pkg.sv ====
package cmt_pkg;

   localparam int pc_w   = 32;      // Word-addressed PC
   localparam int dw     = 32;
   localparam int prf_aw = 6;       // 64 physical registers

   typedef enum logic [1:0]
   {
      lsu_none  = 2'd0,
      lsu_load  = 2'd1,
      lsu_store = 2'd2
   } lsu_op_e;

   typedef enum logic [1:0]
   {
      epu_none    = 2'd0,
      epu_mfsr    = 2'd1,           // Special-register read
      epu_mtsr    = 2'd2,           // Special-register write
      epu_syscall = 2'd3
   } epu_op_e;

   typedef enum logic [1:0]
   {
      br_none = 2'd0,
      br_bcc  = 2'd1,               // Conditional
      br_brel = 2'd2,               // PC-relative
      br_breg = 2'd3                // Register indirect
   } br_kind_e;

   typedef enum logic
   {
      unit_idle    = 1'b0,
      unit_pending = 1'b1
   } unit_state_e;

   // One entry at the head of the reorder buffer
   typedef struct packed {
      logic              valid;
      lsu_op_e           lsu_op;
      epu_op_e           epu_op;
      br_kind_e          br_kind;
      logic              fls;       // Mispredicted branch
      logic              exc;       // Exception raised earlier in the pipe
      logic [pc_w-1:0]   pc;
      logic [prf_aw-1:0] prd;
      logic              prd_we;
      logic [dw-1:0]     opera;     // Address or redirect target
      logic [dw-1:0]     operb;     // Store or SR write data
      logic              pred_taken;
      logic [pc_w-1:0]   pred_tgt;
   } cmt_slot_t;

   typedef struct packed {
      logic            lsu_valid;
      logic            epu_valid;
      lsu_op_e         lsu_op;
      epu_op_e         epu_op;
      logic [dw-1:0]   opera;
      logic [dw-1:0]   operb;
      logic [pc_w-1:0] pc;
      logic [pc_w-1:0] npc;
   } unit_req_t;

   typedef struct packed {
      logic            lsu_done;
      logic [dw-1:0]   lsu_dout;
      logic            epu_done;
      logic [dw-1:0]   epu_dout;
      logic            exc;         // Qualified by epu_done
      logic [pc_w-1:0] exc_tgt;
   } unit_rsp_t;

   typedef struct packed {
      logic              we;
      logic [prf_aw-1:0] addr;
      logic [dw-1:0]     data;
   } prf_wr_t;

   typedef struct packed {
      logic            valid;
      br_kind_e        kind;
      logic            taken;
      logic [pc_w-1:0] pc;
      logic [pc_w-1:0] npc_act;
   } bpu_upd_t;

   typedef struct packed {
      logic            flush;
      logic [pc_w-1:0] tgt;
   } redirect_t;

endpackage

// ==== src/cmt_select.sv ====
`timescale 1ns/10ps

module cmt_select
   import cmt_pkg::*;
#(
   parameter int p_cw = 2
)
(
   input  cmt_slot_t [(1<<p_cw)-1:0] slots,
   input  logic                      commit_en,
   input  logic                      flush,
   input  logic                      se_flush,
   output logic [(1<<p_cw)-1:0]      fire,
   output logic [p_cw:0]             pop_size,
   output logic                      lsu_req0,
   output logic                      epu_req0
);
   localparam int cw = 1 << p_cw;

   logic [cw-1:0] is_valid;
   logic [cw-1:0] is_lsu;
   logic [cw-1:0] is_epu;
   logic [cw-1:0] is_br;
   logic [cw-1:0] is_fls;
   logic [cw-1:0] single_fu;
   logic [cw-1:0] mask;

   // Per-slot classification
   always_comb
   begin
      for (int i = 0; i < cw; i++)
      begin
         is_valid[i] = slots[i].valid;
         is_lsu[i]   = (slots[i].lsu_op != lsu_none);
         is_epu[i]   = (slots[i].epu_op != epu_none) | slots[i].exc; // EPU handles exceptions
         is_br[i]    = (slots[i].br_kind != br_none);
         is_fls[i]   = slots[i].fls;
      end
   end

   // These may only retire from slot 0
   assign single_fu = is_lsu | is_epu | is_br | is_fls;

   // Slot 0 unit requests, held off in the cycle after a mispredict
   assign lsu_req0 = ~se_flush & is_valid[0] & is_lsu[0];
   assign epu_req0 = ~se_flush & is_valid[0] & is_epu[0];

   // In-order mask, stops at the first hole or single-unit slot past 0
   always_comb
   begin
      mask[0] = commit_en & ~flush & is_valid[0];
      for (int j = 1; j < cw; j++)
      begin
         mask[j] = mask[j-1] & is_valid[j] & ~single_fu[j];
      end
   end

   assign fire = mask;

   // Number of entries popped from the ROB
   always_comb
   begin
      pop_size = '0;
      for (int k = 0; k < cw; k++)
      begin
         pop_size = pop_size + (p_cw+1)'(fire[k]);
      end
   end

endmodule

// ==== src/cmt_top.sv ====
`timescale 1ns/10ps

module cmt_top
   import cmt_pkg::*;
#(
   parameter int p_cw = 2
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  cmt_slot_t [(1<<p_cw)-1:0] slots,
   input  unit_rsp_t                 unit_rsp,
   output logic [(1<<p_cw)-1:0]      fire,
   output logic [p_cw:0]             pop_size,
   output unit_req_t                 unit_req,
   output prf_wr_t                   prf_wr,
   output bpu_upd_t                  bpu,
   output redirect_t                 redirect
);
   logic commit_en;
   logic flush;
   logic se_flush;
   logic lsu_req0;
   logic epu_req0;

   // Commit mask and pop count
   cmt_select
   #(
      .p_cw      (p_cw)
   )
   u_select
   (
      .slots     (slots),
      .commit_en (commit_en),
      .flush     (flush),
      .se_flush  (se_flush),
      .fire      (fire),
      .pop_size  (pop_size),
      .lsu_req0  (lsu_req0),
      .epu_req0  (epu_req0)
   );

   // LSU/EPU request and writeback
   cmt_unit_req u_unit_req
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .lsu_req0  (lsu_req0),
      .epu_req0  (epu_req0),
      .flush     (flush),
      .slot0     (slots[0]),
      .unit_rsp  (unit_rsp),
      .commit_en (commit_en),
      .unit_req  (unit_req),
      .prf_wr    (prf_wr)
   );

   // Flush and BPU update
   cmt_branch_resolve u_branch_resolve
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .fire0     (fire[0]),
      .slot0     (slots[0]),
      .unit_rsp  (unit_rsp),
      .se_flush  (se_flush),
      .flush     (flush),
      .redirect  (redirect),
      .bpu       (bpu)
   );

endmodule

// ==== src/cmt_unit_req.sv ====
`timescale 1ns/10ps

module cmt_unit_req
   import cmt_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      lsu_req0,
   input  logic      epu_req0,
   input  logic      flush,
   input  cmt_slot_t slot0,
   input  unit_rsp_t unit_rsp,
   output logic      commit_en,
   output unit_req_t unit_req,
   output prf_wr_t   prf_wr
);
   unit_state_e     state_q;
   unit_state_e     state_nxt;
   logic            pipe_req;
   logic            pipe_done;
   logic            issue;
   logic [pc_w-1:0] npc;

   assign pipe_req  = lsu_req0 | epu_req0;
   assign pipe_done = unit_rsp.lsu_done | unit_rsp.epu_done;

   // Strobe only once per operation
   assign issue = (state_q == unit_idle);

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         unit_idle:
         begin
            if (pipe_req)
               state_nxt = unit_pending;
         end
         unit_pending:
         begin
            if (pipe_done)
               state_nxt = unit_idle;
         end
         default:
         begin
            state_nxt = unit_idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_q <= unit_idle;
      else
         state_q <= state_nxt;
   end

   // Slot 0 waits for its unit, done cycle lets it through
   assign commit_en = ~pipe_req | pipe_done;

   assign npc = slot0.pc + pc_w'(1);   // Return address for syscall

   always_comb
   begin
      unit_req.lsu_valid = issue & lsu_req0;
      unit_req.epu_valid = issue & epu_req0;
      unit_req.lsu_op    = slot0.lsu_op;
      unit_req.epu_op    = slot0.epu_op;
      unit_req.opera     = slot0.opera;
      unit_req.operb     = slot0.operb;
      unit_req.pc        = slot0.pc;
      unit_req.npc       = npc;
   end

   // Writeback of the unit result
   always_comb
   begin
      prf_wr.we   = pipe_done & ~flush & slot0.prd_we;
      prf_wr.addr = slot0.prd;
      if (unit_rsp.epu_done)
         prf_wr.data = unit_rsp.epu_dout;
      else
         prf_wr.data = unit_rsp.lsu_dout;
   end

endmodule
